/* Makefile */
TOP := tb_mem_subsys
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

obj_dir/V$(TOP): filelist.f design/*.sv tests/*.sv tests/mem_patterns.txt
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f
	verilator --lint-only -Wall --top-module mem_subsys_top design/sram_pkg.sv \
		design/axi_sram.sv design/axi_arbiter.sv design/mem_subsys_top.sv

clean:
	rm -rf obj_dir $(LOG)

/* design/axi_arbiter.sv */
`timescale 1ns/1ps

module axi_arbiter (
  input  logic            aclk,
  input  logic            areset,
  input  logic            m0_arvalid,
  input  sram_pkg::addr_t m0_araddr,
  output logic            m0_arready,
  output sram_pkg::data_t m0_rdata,
  output sram_pkg::resp_t m0_rresp,
  output logic            m0_rvalid,
  input  logic            m0_rready,
  input  logic            m0_awvalid,
  input  sram_pkg::addr_t m0_awaddr,
  output logic            m0_awready,
  input  logic            m0_wvalid,
  input  sram_pkg::data_t m0_wdata,
  input  sram_pkg::strb_t m0_wstrb,
  output logic            m0_wready,
  output logic            m0_bvalid,
  output sram_pkg::resp_t m0_bresp,
  input  logic            m0_bready,
  input  logic            m1_arvalid,
  input  sram_pkg::addr_t m1_araddr,
  output logic            m1_arready,
  output sram_pkg::data_t m1_rdata,
  output sram_pkg::resp_t m1_rresp,
  output logic            m1_rvalid,
  input  logic            m1_rready,
  input  logic            m1_awvalid,
  input  sram_pkg::addr_t m1_awaddr,
  output logic            m1_awready,
  input  logic            m1_wvalid,
  input  sram_pkg::data_t m1_wdata,
  input  sram_pkg::strb_t m1_wstrb,
  output logic            m1_wready,
  output logic            m1_bvalid,
  output sram_pkg::resp_t m1_bresp,
  input  logic            m1_bready,
  output sram_pkg::addr_t s_araddr,
  output logic            s_arvalid,
  input  logic            s_arready,
  input  sram_pkg::data_t s_rdata,
  input  sram_pkg::resp_t s_rresp,
  input  logic            s_rvalid,
  output logic            s_rready,
  output sram_pkg::addr_t s_awaddr,
  output logic            s_awvalid,
  input  logic            s_awready,
  output sram_pkg::data_t s_wdata,
  output sram_pkg::strb_t s_wstrb,
  output logic            s_wvalid,
  input  logic            s_wready,
  input  logic            s_bvalid,
  input  sram_pkg::resp_t s_bresp,
  output logic            s_bready
);

  typedef enum logic [1:0] {arb_idle, read_busy, write_busy} arb_state_t;

  arb_state_t state;
  logic       grant;     // 0 fetch, 1 data
  logic       last_win;
  logic       req0;
  logic       req1;
  logic       pick;
  logic       pick_read;
  logic       rd0;
  logic       rd1;
  logic       wr0;
  logic       wr1;

  // a write only counts once both address and data are offered
  assign req0 = m0_arvalid || (m0_awvalid && m0_wvalid);
  assign req1 = m1_arvalid || (m1_awvalid && m1_wvalid);
  assign pick = (req0 && req1) ? !last_win : req1;
  assign pick_read = pick ? m1_arvalid : m0_arvalid;  // reads go first

  always_ff @(posedge aclk) begin
    if (areset) begin
      state    <= arb_idle;
      grant    <= 1'b0;
      last_win <= 1'b1;  // fetch wins the first tie
    end else begin
      case (state)
        arb_idle: begin
          if (req0 || req1) begin
            grant    <= pick;
            last_win <= pick;
            if (pick_read) begin
              state <= read_busy;
            end else begin
              state <= write_busy;
            end
          end
        end
        read_busy: begin
          if (s_rvalid && s_rready) begin
            state <= arb_idle;
          end
        end
        write_busy: begin
          if (s_bvalid && s_bready) begin
            state <= arb_idle;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

  assign rd0 = (state == read_busy) && !grant;
  assign rd1 = (state == read_busy) && grant;
  assign wr0 = (state == write_busy) && !grant;
  assign wr1 = (state == write_busy) && grant;

  assign s_araddr  = grant ? m1_araddr : m0_araddr;
  assign s_arvalid = (rd0 && m0_arvalid) || (rd1 && m1_arvalid);
  assign s_rready  = (rd0 && m0_rready) || (rd1 && m1_rready);
  assign s_awaddr  = grant ? m1_awaddr : m0_awaddr;
  assign s_awvalid = (wr0 && m0_awvalid) || (wr1 && m1_awvalid);
  assign s_wdata   = grant ? m1_wdata : m0_wdata;
  assign s_wstrb   = grant ? m1_wstrb : m0_wstrb;
  assign s_wvalid  = (wr0 && m0_wvalid) || (wr1 && m1_wvalid);
  assign s_bready  = (wr0 && m0_bready) || (wr1 && m1_bready);

  assign m0_arready = rd0 && s_arready;
  assign m0_rvalid  = rd0 && s_rvalid;
  assign m0_rdata   = s_rdata;  // payload shared, valid qualifies it
  assign m0_rresp   = s_rresp;
  assign m0_awready = wr0 && s_awready;
  assign m0_wready  = wr0 && s_wready;
  assign m0_bvalid  = wr0 && s_bvalid;
  assign m0_bresp   = s_bresp;

  assign m1_arready = rd1 && s_arready;
  assign m1_rvalid  = rd1 && s_rvalid;
  assign m1_rdata   = s_rdata;
  assign m1_rresp   = s_rresp;
  assign m1_awready = wr1 && s_awready;
  assign m1_wready  = wr1 && s_wready;
  assign m1_bvalid  = wr1 && s_bvalid;
  assign m1_bresp   = s_bresp;

  a_one_kind: assert property (@(posedge aclk) disable iff (areset)
    !((s_arvalid || s_rready || s_rvalid) && (s_awvalid || s_wvalid || s_bready || s_bvalid)));

  // stalled response keeps the same owner
  a_grant_hold: assert property (@(posedge aclk) disable iff (areset)
    (s_rvalid && !s_rready) || (s_bvalid && !s_bready) |=> $stable(grant) && state != arb_idle);

endmodule

/* design/axi_sram.sv */
`timescale 1ns/1ps

module axi_sram #(
  parameter int read_cycles = 1
) (
  input  logic            aclk,
  input  logic            areset,
  input  sram_pkg::addr_t araddr,
  input  logic            arvalid,
  output logic            arready,
  output sram_pkg::data_t rdata,
  output sram_pkg::resp_t rresp,
  output logic            rvalid,
  input  logic            rready,
  input  sram_pkg::addr_t awaddr,
  input  logic            awvalid,
  output logic            awready,
  input  sram_pkg::data_t wdata,
  input  sram_pkg::strb_t wstrb,
  input  logic            wvalid,
  output logic            wready,
  output logic            bvalid,
  output sram_pkg::resp_t bresp,
  input  logic            bready
);

  typedef enum logic [1:0] {rd_idle, rd_wait, rd_resp} rd_state_t;
  typedef enum logic [1:0] {wr_idle, wr_collect, wr_resp} wr_state_t;
  typedef logic [$clog2(read_cycles + 1)-1:0] cnt_t;

  sram_pkg::data_t mem [sram_pkg::MEM_WORDS];

  logic            ports_en;
  rd_state_t       rd_state;
  cnt_t            rd_cnt;
  logic            ar_hs;
  logic            rd_load;
  sram_pkg::addr_t ar_addr_q;
  sram_pkg::addr_t rd_addr;
  sram_pkg::widx_t rd_idx;
  logic            rd_in_range;

  wr_state_t       wr_state;
  logic            aw_got;
  logic            w_got;
  logic            aw_hs;
  logic            w_hs;
  logic            wr_commit;
  sram_pkg::addr_t aw_addr_q;
  sram_pkg::data_t w_data_q;
  sram_pkg::strb_t w_strb_q;
  sram_pkg::widx_t wr_idx;
  logic            wr_in_range;

  always_ff @(posedge aclk) begin
    if (areset) begin
      ports_en <= 1'b0;
    end else begin
      ports_en <= 1'b1;  // readies come up the cycle after reset
    end
  end

  assign arready = ports_en && (rd_state == rd_idle);
  assign ar_hs   = arvalid && arready;
  assign rvalid  = (rd_state == rd_resp);

  // with a single cycle of latency the array is read straight off the bus address
  assign rd_addr     = (rd_state == rd_idle) ? araddr : ar_addr_q;
  assign rd_idx      = rd_addr[sram_pkg::IDX_W+1:2];
  assign rd_in_range = (rd_addr >> 2) < sram_pkg::MEM_WORDS;
  assign rd_load     = (ar_hs && read_cycles == 1) || (rd_state == rd_wait && rd_cnt == '0);

  always_ff @(posedge aclk) begin
    if (areset) begin
      rd_state <= rd_idle;
      rd_cnt   <= '0;
    end else begin
      case (rd_state)
        rd_idle: begin
          if (ar_hs) begin
            if (read_cycles > 1) begin
              rd_cnt   <= cnt_t'(read_cycles - 2);
              rd_state <= rd_wait;
            end else begin
              rd_state <= rd_resp;
            end
          end
        end
        rd_wait: begin
          if (rd_cnt == '0) begin
            rd_state <= rd_resp;
          end else begin
            rd_cnt <= rd_cnt - 1'b1;
          end
        end
        rd_resp: begin
          if (rready) begin
            rd_state <= rd_idle;
          end
        end
        default: rd_state <= rd_idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (ar_hs) begin
      ar_addr_q <= araddr;
    end
    if (rd_load) begin
      rdata <= rd_in_range ? mem[rd_idx] : '0;
      rresp <= rd_in_range ? sram_pkg::RESP_OKAY : sram_pkg::RESP_SLVERR;
    end
  end

  assign awready = ports_en && (wr_state != wr_resp) && !aw_got;
  assign wready  = ports_en && (wr_state != wr_resp) && !w_got;
  assign aw_hs   = awvalid && awready;
  assign w_hs    = wvalid && wready;
  assign bvalid  = (wr_state == wr_resp);

  assign wr_idx      = aw_addr_q[sram_pkg::IDX_W+1:2];
  assign wr_in_range = (aw_addr_q >> 2) < sram_pkg::MEM_WORDS;
  assign wr_commit   = (wr_state == wr_collect) && aw_got && w_got;

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_state <= wr_idle;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
    end else begin
      case (wr_state)
        wr_idle, wr_collect: begin
          if (aw_hs) begin
            aw_got <= 1'b1;
          end
          if (w_hs) begin
            w_got <= 1'b1;
          end
          if (aw_hs || w_hs) begin
            wr_state <= wr_collect;
          end
          if (wr_commit) begin  // both halves in, array written this edge
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            wr_state <= wr_resp;
          end
        end
        wr_resp: begin
          if (bready) begin
            wr_state <= wr_idle;
          end
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (aw_hs) begin
      aw_addr_q <= awaddr;
    end
    if (w_hs) begin
      w_data_q <= wdata;
      w_strb_q <= wstrb;
    end
    if (wr_commit) begin
      bresp <= wr_in_range ? sram_pkg::RESP_OKAY : sram_pkg::RESP_SLVERR;
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_commit && wr_in_range) begin
      for (int b = 0; b < $bits(sram_pkg::strb_t); b++) begin
        if (w_strb_q[b]) begin
          mem[wr_idx][b*8 +: 8] <= w_data_q[b*8 +: 8];  // byte lane merge
        end
      end
    end
  end

  a_rvalid_hold: assert property (@(posedge aclk) disable iff (areset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

  a_bvalid_hold: assert property (@(posedge aclk) disable iff (areset)
    bvalid && !bready |=> bvalid && $stable(bresp));

  // no new address accepted until the data is out
  a_read_busy: assert property (@(posedge aclk) disable iff (areset)
    ar_hs |-> ##read_cycles (rvalid && !arready));

endmodule

/* design/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic            aclk,
  input  logic            areset,
  input  logic            m0_arvalid,
  input  sram_pkg::addr_t m0_araddr,
  output logic            m0_arready,
  output sram_pkg::data_t m0_rdata,
  output sram_pkg::resp_t m0_rresp,
  output logic            m0_rvalid,
  input  logic            m0_rready,
  input  logic            m0_awvalid,
  input  sram_pkg::addr_t m0_awaddr,
  output logic            m0_awready,
  input  logic            m0_wvalid,
  input  sram_pkg::data_t m0_wdata,
  input  sram_pkg::strb_t m0_wstrb,
  output logic            m0_wready,
  output logic            m0_bvalid,
  output sram_pkg::resp_t m0_bresp,
  input  logic            m0_bready,
  input  logic            m1_arvalid,
  input  sram_pkg::addr_t m1_araddr,
  output logic            m1_arready,
  output sram_pkg::data_t m1_rdata,
  output sram_pkg::resp_t m1_rresp,
  output logic            m1_rvalid,
  input  logic            m1_rready,
  input  logic            m1_awvalid,
  input  sram_pkg::addr_t m1_awaddr,
  output logic            m1_awready,
  input  logic            m1_wvalid,
  input  sram_pkg::data_t m1_wdata,
  input  sram_pkg::strb_t m1_wstrb,
  output logic            m1_wready,
  output logic            m1_bvalid,
  output sram_pkg::resp_t m1_bresp,
  input  logic            m1_bready
);

  sram_pkg::addr_t s_araddr;
  logic            s_arvalid;
  logic            s_arready;
  sram_pkg::data_t s_rdata;
  sram_pkg::resp_t s_rresp;
  logic            s_rvalid;
  logic            s_rready;
  sram_pkg::addr_t s_awaddr;
  logic            s_awvalid;
  logic            s_awready;
  sram_pkg::data_t s_wdata;
  sram_pkg::strb_t s_wstrb;
  logic            s_wvalid;
  logic            s_wready;
  logic            s_bvalid;
  sram_pkg::resp_t s_bresp;
  logic            s_bready;

  axi_arbiter u_arbiter (.*);  // master and s_ names line up one to one

  axi_sram #(
    .read_cycles(sram_pkg::READ_CYCLES)
  ) u_sram (
    .aclk    (aclk),
    .areset  (areset),
    .araddr  (s_araddr),
    .arvalid (s_arvalid),
    .arready (s_arready),
    .rdata   (s_rdata),
    .rresp   (s_rresp),
    .rvalid  (s_rvalid),
    .rready  (s_rready),
    .awaddr  (s_awaddr),
    .awvalid (s_awvalid),
    .awready (s_awready),
    .wdata   (s_wdata),
    .wstrb   (s_wstrb),
    .wvalid  (s_wvalid),
    .wready  (s_wready),
    .bvalid  (s_bvalid),
    .bresp   (s_bresp),
    .bready  (s_bready)
  );

endmodule

/* design/sram_pkg.sv */
package sram_pkg;

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // one enable per byte lane
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  localparam int MEM_WORDS = 256;  // 1 KiB of storage
  localparam int IDX_W     = $clog2(MEM_WORDS);

  typedef logic [IDX_W-1:0] widx_t;  // word index, byte address bits 9:2

  localparam int READ_CYCLES = 2;  // ar handshake to rvalid

endpackage

/* filelist.f */
design/sram_pkg.sv
design/axi_sram.sv
design/axi_arbiter.sv
design/mem_subsys_top.sv
tests/tb_clock.sv
tests/tb_mem_subsys.sv

/* tests/mem_patterns.txt */
// test master op(1 write, 0 read) addr data strb exp_resp exp_data, all hex
// writes leave exp_data at 0, error responses do not check data
1 0 1 00000000 11223344 f 0 00000000
1 0 0 00000000 00000000 0 0 11223344
2 0 1 00000010 a1b2c3d4 f 0 00000000
2 0 1 00000010 55667788 3 0 00000000
2 0 0 00000010 00000000 0 0 a1b27788
2 0 1 00000010 99000000 8 0 00000000
2 0 0 00000010 00000000 0 0 99b27788
3 0 1 00000100 cafe0001 f 0 00000000
3 1 1 00000200 beef0002 f 0 00000000
3 0 1 00000104 cafe0003 f 0 00000000
3 1 1 00000204 beef0004 f 0 00000000
3 0 0 00000100 00000000 0 0 cafe0001
3 1 0 00000200 00000000 0 0 beef0002
3 0 0 00000104 00000000 0 0 cafe0003
3 1 0 00000204 00000000 0 0 beef0004
4 1 1 00000300 0badf00d f 0 00000000
4 0 1 00000304 12345678 f 0 00000000
4 1 0 00000300 00000000 0 0 0badf00d
4 0 0 00000304 00000000 0 0 12345678
4 1 0 00000010 00000000 0 0 99b27788
5 0 0 00000400 00000000 0 2 00000000
5 1 1 00000400 deadbeef f 2 00000000
5 0 1 00000410 00000000 f 2 00000000
5 1 0 00000000 00000000 0 0 11223344
5 0 0 00000010 00000000 0 0 99b27788

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int half_period = 50
) (
  output logic aclk
);

  initial begin
    aclk = 1'b0;
    forever #half_period aclk = ~aclk;  // 100 ns period
  end

endmodule

/* tests/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;

  localparam int N_PAT          = 25;
  localparam int N_FLD          = 8;
  localparam int TIMEOUT_CYCLES = N_PAT * 40 + 200;
  localparam int SEED           = 32'h42f2_b2fb;

  logic            aclk;
  logic            areset;
  logic            arvalid [2];
  sram_pkg::addr_t araddr  [2];
  logic            arready [2];
  sram_pkg::data_t rdata   [2];
  sram_pkg::resp_t rresp   [2];
  logic            rvalid  [2];
  logic            rready  [2];
  logic            awvalid [2];
  sram_pkg::addr_t awaddr  [2];
  logic            awready [2];
  logic            wvalid  [2];
  sram_pkg::data_t wdata   [2];
  sram_pkg::strb_t wstrb   [2];
  logic            wready  [2];
  logic            bvalid  [2];
  sram_pkg::resp_t bresp   [2];
  logic            bready  [2];

  logic ar_hs_q [2];  // handshake seen on the last rising edge
  logic aw_hs_q [2];
  logic w_hs_q  [2];
  logic r_hs_q  [2];
  logic b_hs_q  [2];

  logic [31:0] pat [N_PAT*N_FLD];
  int          errors = 0;
  int          cycles = 0;
  int          done_cnt;

  tb_clock u_clock (.aclk(aclk));

  mem_subsys_top dut (
    .aclk       (aclk),
    .areset     (areset),
    .m0_arvalid (arvalid[0]),
    .m0_araddr  (araddr[0]),
    .m0_arready (arready[0]),
    .m0_rdata   (rdata[0]),
    .m0_rresp   (rresp[0]),
    .m0_rvalid  (rvalid[0]),
    .m0_rready  (rready[0]),
    .m0_awvalid (awvalid[0]),
    .m0_awaddr  (awaddr[0]),
    .m0_awready (awready[0]),
    .m0_wvalid  (wvalid[0]),
    .m0_wdata   (wdata[0]),
    .m0_wstrb   (wstrb[0]),
    .m0_wready  (wready[0]),
    .m0_bvalid  (bvalid[0]),
    .m0_bresp   (bresp[0]),
    .m0_bready  (bready[0]),
    .m1_arvalid (arvalid[1]),
    .m1_araddr  (araddr[1]),
    .m1_arready (arready[1]),
    .m1_rdata   (rdata[1]),
    .m1_rresp   (rresp[1]),
    .m1_rvalid  (rvalid[1]),
    .m1_rready  (rready[1]),
    .m1_awvalid (awvalid[1]),
    .m1_awaddr  (awaddr[1]),
    .m1_awready (awready[1]),
    .m1_wvalid  (wvalid[1]),
    .m1_wdata   (wdata[1]),
    .m1_wstrb   (wstrb[1]),
    .m1_wready  (wready[1]),
    .m1_bvalid  (bvalid[1]),
    .m1_bresp   (bresp[1]),
    .m1_bready  (bready[1])
  );

  always @(posedge aclk) begin
    for (int m = 0; m < 2; m++) begin
      ar_hs_q[m] <= arvalid[m] && arready[m];
      aw_hs_q[m] <= awvalid[m] && awready[m];
      w_hs_q[m]  <= wvalid[m] && wready[m];
      r_hs_q[m]  <= rvalid[m] && rready[m];
      b_hs_q[m]  <= bvalid[m] && bready[m];
    end
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles with transactions still pending", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  function automatic logic [31:0] pat_field(input int line, input int fld);
    return pat[line*N_FLD+fld];
  endfunction

  task automatic do_read(input int m, input sram_pkg::addr_t addr,
                         input sram_pkg::resp_t exp_resp, input sram_pkg::data_t exp_data);
    sram_pkg::data_t held_data;
    sram_pkg::resp_t held_resp;
    int              stall;
    @(negedge aclk);
    araddr[m]  = addr;
    arvalid[m] = 1'b1;
    do @(negedge aclk); while (!ar_hs_q[m]);
    arvalid[m] = 1'b0;
    while (!rvalid[m]) @(negedge aclk);
    held_data = rdata[m];
    held_resp = rresp[m];
    stall     = $urandom_range(3, 0);
    repeat (stall) begin  // response must hold while rready is low
      @(negedge aclk);
      check($sformatf("m%0d rvalid", m), 32'(rvalid[m]), 32'd1);
      check($sformatf("m%0d rdata", m), rdata[m], held_data);
      check($sformatf("m%0d rresp", m), 32'(rresp[m]), 32'(held_resp));
    end
    rready[m] = 1'b1;
    do @(negedge aclk); while (!r_hs_q[m]);
    rready[m] = 1'b0;
    check($sformatf("m%0d rresp", m), 32'(held_resp), 32'(exp_resp));
    if (exp_resp == sram_pkg::RESP_OKAY) begin
      check($sformatf("m%0d rdata", m), held_data, exp_data);
    end
  endtask

  task automatic do_write(input int m, input sram_pkg::addr_t addr, input sram_pkg::data_t data,
                          input sram_pkg::strb_t strb, input sram_pkg::resp_t exp_resp);
    sram_pkg::resp_t held_resp;
    int              stall;
    @(negedge aclk);
    awaddr[m]  = addr;
    wdata[m]   = data;
    wstrb[m]   = strb;
    awvalid[m] = 1'b1;
    wvalid[m]  = 1'b1;
    while (awvalid[m] || wvalid[m]) begin  // aw and w may finish apart
      @(negedge aclk);
      if (aw_hs_q[m]) begin
        awvalid[m] = 1'b0;
      end
      if (w_hs_q[m]) begin
        wvalid[m] = 1'b0;
      end
    end
    while (!bvalid[m]) @(negedge aclk);
    held_resp = bresp[m];
    stall     = $urandom_range(3, 0);
    repeat (stall) begin
      @(negedge aclk);
      check($sformatf("m%0d bvalid", m), 32'(bvalid[m]), 32'd1);
      check($sformatf("m%0d bresp", m), 32'(bresp[m]), 32'(held_resp));
    end
    bready[m] = 1'b1;
    do @(negedge aclk); while (!b_hs_q[m]);
    bready[m] = 1'b0;
    check($sformatf("m%0d bresp", m), 32'(held_resp), 32'(exp_resp));
  endtask

  task automatic run_master(input int m, input int t);
    for (int i = 0; i < N_PAT; i++) begin
      if (pat_field(i, 0) == t && pat_field(i, 1) == m) begin
        if (pat_field(i, 2) == 1) begin
          do_write(m, pat_field(i, 3), pat_field(i, 4), sram_pkg::strb_t'(pat_field(i, 5)),
                   sram_pkg::resp_t'(pat_field(i, 6)));
        end else begin
          do_read(m, pat_field(i, 3), sram_pkg::resp_t'(pat_field(i, 6)), pat_field(i, 7));
        end
        done_cnt++;
      end
    end
  endtask

  initial begin
    int errs_before;
    int tests_failed;
    void'($urandom(SEED));
    tests_failed = 0;
    areset       = 1'b1;
    for (int m = 0; m < 2; m++) begin
      arvalid[m] = 1'b0;
      araddr[m]  = '0;
      rready[m]  = 1'b0;
      awvalid[m] = 1'b0;
      awaddr[m]  = '0;
      wvalid[m]  = 1'b0;
      wdata[m]   = '0;
      wstrb[m]   = '0;
      bready[m]  = 1'b0;
    end
    $readmemh("tests/mem_patterns.txt", pat);
    if ($isunknown(pat[0])) begin
      $display("pattern file tests/mem_patterns.txt could not be read");
      errors++;
    end
    repeat (10) @(negedge aclk);
    areset = 1'b0;

    // responses quiet right after reset
    @(negedge aclk);
    errs_before = errors;
    for (int m = 0; m < 2; m++) begin
      check($sformatf("m%0d rvalid", m), 32'(rvalid[m]), 32'd0);
      check($sformatf("m%0d bvalid", m), 32'(bvalid[m]), 32'd0);
    end
    $display("test 6: %s", (errors == errs_before) ? "ok" : "failed");
    tests_failed += (errors == errs_before) ? 0 : 1;

    for (int t = 1; t <= 5; t++) begin
      errs_before = errors;
      done_cnt    = 0;
      fork
        run_master(0, t);
        run_master(1, t);
      join
      $display("test %0d: %s, %0d transactions", t, (errors == errs_before) ? "ok" : "failed",
               done_cnt);
      tests_failed += (errors == errs_before) ? 0 : 1;
    end

    $display("tests run 6, tests failed %0d, checks failed %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
